// ==== rtl/crc24_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// CRC24 constants and pure functions shared by the checker datapath
// word CRCs start from a zero register, seeds are added by linearity
////////////////////////////////////////////////////////////////////////////

package crc24_pkg;

	// a running or computed CRC24 value
	typedef logic [23:0] crc24_t;

	// generator polynomial without the implicit x^24 term
	localparam crc24_t crc_poly = 24'h328B63;

	// register value at the start of every segment
	localparam crc24_t crc_seed = 24'hffffff;

	////////////////////////////////////////////////////////////////////////
	// bit level step
	////////////////////////////////////////////////////////////////////////

	// one shift of the LFSR with one message bit coming in
	// the feedback is the outgoing msb xored with the message bit
	function automatic crc24_t crc24_step(input crc24_t c, input logic b);
		logic fb;
		fb = c[23] ^ b;
		return {c[22:0], 1'b0} ^ (fb ? crc_poly : 24'h0);
	endfunction

	////////////////////////////////////////////////////////////////////////
	// word level functions
	////////////////////////////////////////////////////////////////////////

	// CRC of one 64 bit word from an all zero register, msb first
	// this unrolls to a flat xor network in synthesis
	function automatic crc24_t crc24_of_word(input logic [63:0] w);
		crc24_t c;
		c = '0;
		for (int i = 63; i >= 0; i--) begin
			c = crc24_step(c, w[i]);
		end
		return c;
	endfunction

	// pushes a register through 64 zero bits
	// the CRC is linear, so the CRC of a word with seed s is
	// crc24_zero64(s) ^ crc24_of_word(word)
	function automatic crc24_t crc24_zero64(input crc24_t c);
		crc24_t r;
		r = c;
		for (int i = 0; i < 64; i++) begin
			r = crc24_step(r, 1'b0);
		end
		return r;
	endfunction

endpackage

// ==== rtl/ilkn_word_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Interlaken style word formats and the records passed between stages
// the control word layout follows the burst control word, crc24 at the bottom
////////////////////////////////////////////////////////////////////////////

package ilkn_word_pkg;

	// burst or idle control word, msb first
	typedef struct packed {
		logic                  burst;
		logic                  sop;
		logic [3:0]            eop_fmt;
		logic                  reset_cal;
		logic                  reserved;
		logic [15:0]           flow;
		logic [7:0]            chan;
		logic [7:0]            multi;
		crc24_pkg::crc24_t     crc24;
	} ctrl_word_t;

	// one 64 bit word, seen as raw bits for the CRC or as
	// control fields when the framing bit says so
	typedef union packed {
		logic [63:0]           raw;
		ctrl_word_t            ctrl;
	} ilkn_word_u;

	// one beat on the input, framing bit on top
	typedef struct packed {
		logic                  is_ctrl;
		ilkn_word_u            word;
	} ilkn_beat_t;

	////////////////////////////////////////////////////////////////////////
	// stage to stage records
	////////////////////////////////////////////////////////////////////////

	// decode to execute
	// data is what the CRC covers, with the control CRC field cleared
	typedef struct packed {
		logic [63:0]           data;
		logic                  first;
		logic                  last;
		crc24_pkg::crc24_t     rx_crc;
	} dec_word_t;

	// execute to result
	// crc is the running value after this word
	typedef struct packed {
		crc24_pkg::crc24_t     crc;
		crc24_pkg::crc24_t     rx_crc;
		logic                  last;
	} acc_result_t;

endpackage

// ==== rtl/word_decode.sv ====
////////////////////////////////////////////////////////////////////////////
// Decode stage of the CRC24 checker, one beat per enabled cycle
// tags segment start and end, splits off the received CRC field
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module word_decode (
	input  logic                      clk,
	input  logic                      arst,
	input  logic                      ena,
	input  logic                      valid,
	input  ilkn_word_pkg::ilkn_beat_t beat,
	output ilkn_word_pkg::dec_word_t  dec,
	output logic                      dec_valid
);

	// goes high with the first control word after reset
	logic seen_ctrl;

	// the next valid beat opens a segment
	logic pending_first;

	// copy of the input word with the CRC field cleared on control beats
	ilkn_word_pkg::ilkn_word_u cov_word;

	always_comb begin
		cov_word = beat.word;
		if (beat.is_ctrl) begin
			cov_word.ctrl.crc24 = '0;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// segment tracking
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			seen_ctrl     <= 1'b0;
			pending_first <= 1'b0;
		end else if (ena && valid) begin
			// every control word closes a segment and opens the next
			pending_first <= beat.is_ctrl;
			if (beat.is_ctrl) begin
				seen_ctrl <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			dec       <= '0;
			dec_valid <= 1'b0;
		end else if (ena) begin
			dec_valid <= valid;
			// a bubble moves the valid bit only, the word holds
			if (valid) begin
				dec.data   <= cov_word.raw;
				dec.first  <= pending_first;
				// the first control word after reset closes nothing
				dec.last   <= beat.is_ctrl && seen_ctrl;
				dec.rx_crc <= beat.word.ctrl.crc24;
			end
		end
	end

	// the source must drive valid cleanly once reset is released
	valid_known_a : assert property (@(posedge clk) disable iff (arst)
		!$isunknown(valid));

endmodule

// ==== rtl/crc24_accum.sv ====
////////////////////////////////////////////////////////////////////////////
// Execute stage, folds each covered word into the running segment CRC
// two enabled cycles: word CRC first, then combine with seed or prior CRC
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module crc24_accum (
	input  logic                       clk,
	input  logic                       arst,
	input  logic                       ena,
	input  ilkn_word_pkg::dec_word_t   dec,
	input  logic                       dec_valid,
	output ilkn_word_pkg::acc_result_t acc,
	output logic                       acc_valid
);

	// the seed pushed through one word of zeros, fixed at elaboration
	localparam crc24_pkg::crc24_t evo_seed =
		crc24_pkg::crc24_zero64(crc24_pkg::crc_seed);

	// some segment has started since reset
	logic opened;

	// stage one registers
	logic              s1_valid;
	logic              s1_first;
	logic              s1_last;
	crc24_pkg::crc24_t s1_wcrc;
	crc24_pkg::crc24_t s1_rx_crc;

	// previous output moved up to the current word position
	crc24_pkg::crc24_t evo_prev;

	// seed term or previous term, picked by the registered first flag
	crc24_pkg::crc24_t carry_in;

	////////////////////////////////////////////////////////////////////////
	// stage one, word CRC from a zero register
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			opened   <= 1'b0;
			s1_valid <= 1'b0;
			s1_first <= 1'b0;
			s1_last  <= 1'b0;
		end else if (ena) begin
			// words ahead of the first opened segment are dropped here
			s1_valid <= dec_valid && (dec.first || opened);
			if (dec_valid) begin
				s1_first <= dec.first;
				s1_last  <= dec.last;
				if (dec.first) begin
					opened <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ena && dec_valid) begin
			s1_wcrc   <= crc24_pkg::crc24_of_word(dec.data);
			s1_rx_crc <= dec.rx_crc;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// stage two, combine and keep the running CRC
	////////////////////////////////////////////////////////////////////////

	always_comb begin
		evo_prev = crc24_pkg::crc24_zero64(acc.crc);
		carry_in = s1_first ? evo_seed : evo_prev;
	end

	// acc.crc is both the reported value and the running register
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			acc       <= '{crc: crc24_pkg::crc_seed, rx_crc: '0, last: 1'b0};
			acc_valid <= 1'b0;
		end else if (ena) begin
			acc_valid <= s1_valid;
			if (s1_valid) begin
				acc.crc    <= s1_wcrc ^ carry_in;
				acc.rx_crc <= s1_rx_crc;
				acc.last   <= s1_last;
			end
		end
	end

	// the decode stage must open a segment before it closes one
	// an empty segment opens and closes on the same word
	last_after_open_a : assert property (@(posedge clk) disable iff (arst)
		(ena && dec_valid && dec.last) |-> (opened || dec.first));

endmodule

// ==== rtl/crc_result_check.sv ====
////////////////////////////////////////////////////////////////////////////
// Result stage, compares the segment CRC with the received field
// done and crc_err are single cycle pulses, err_count saturates
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module crc_result_check #(
	parameter int err_cnt_w = 16
) (
	input  logic                       clk,
	input  logic                       arst,
	input  logic                       ena,
	input  ilkn_word_pkg::acc_result_t acc,
	input  logic                       acc_valid,
	output logic                       done,
	output logic                       crc_err,
	output crc24_pkg::crc24_t          crc_value,
	output logic [err_cnt_w-1:0]       err_count
);

	// a closing word is in the execute output this cycle
	logic check;
	logic mismatch;

	assign check    = ena && acc_valid && acc.last;
	assign mismatch = acc.crc != acc.rx_crc;

	////////////////////////////////////////////////////////////////////////
	// pulses and held result
	////////////////////////////////////////////////////////////////////////

	// the pulses drop on the next edge even during a stall,
	// so each segment is reported exactly once
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			done      <= 1'b0;
			crc_err   <= 1'b0;
			crc_value <= crc24_pkg::crc_seed;
		end else begin
			done    <= check;
			crc_err <= check && mismatch;
			if (check) begin
				crc_value <= acc.crc;
			end
		end
	end

	// error counter, holds at all ones
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			err_count <= '0;
		end else if (check && mismatch && err_count != '1) begin
			err_count <= err_count + 1'b1;
		end
	end

	// a segment is only judged on known values from the execute stage
	crc_known_a : assert property (@(posedge clk) disable iff (arst)
		check |-> !$isunknown({acc.crc, acc.rx_crc}));

endmodule

// ==== rtl/crc24_checker_top.sv ====
////////////////////////////////////////////////////////////////////////////
// CRC24 checker for a 64 bit Interlaken style word stream
// decode, execute and result stages, done four enabled cycles after a close
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module crc24_checker_top #(
	parameter int err_cnt_w = 16
) (
	input  logic                      clk,
	input  logic                      arst,
	input  logic                      ena,
	input  logic                      valid,
	input  ilkn_word_pkg::ilkn_beat_t beat,
	output logic                      done,
	output logic                      crc_err,
	output crc24_pkg::crc24_t         crc_value,
	output logic [err_cnt_w-1:0]      err_count
);

	// decode to execute
	ilkn_word_pkg::dec_word_t   dec;
	logic                       dec_valid;

	// execute to result
	ilkn_word_pkg::acc_result_t acc;
	logic                       acc_valid;

	word_decode word_decode_i (
		.clk       (clk),
		.arst      (arst),
		.ena       (ena),
		.valid     (valid),
		.beat      (beat),
		.dec       (dec),
		.dec_valid (dec_valid)
	);

	crc24_accum crc24_accum_i (
		.clk       (clk),
		.arst      (arst),
		.ena       (ena),
		.dec       (dec),
		.dec_valid (dec_valid),
		.acc       (acc),
		.acc_valid (acc_valid)
	);

	crc_result_check #(
		.err_cnt_w (err_cnt_w)
	) crc_result_check_i (
		.clk       (clk),
		.arst      (arst),
		.ena       (ena),
		.acc       (acc),
		.acc_valid (acc_valid),
		.done      (done),
		.crc_err   (crc_err),
		.crc_value (crc_value),
		.err_count (err_count)
	);

endmodule

// ==== bench/crc24_ref.svh ====
////////////////////////////////////////////////////////////////////////////
// Bit serial CRC24 model and xorshift generator for the checker testbench
// included inside the testbench module, so everything here is module scope
////////////////////////////////////////////////////////////////////////////

`ifndef CRC24_REF_SVH
`define CRC24_REF_SVH

// polynomial and start value of the Interlaken CRC24
localparam logic [23:0] ref_poly = 24'h328B63;
localparam logic [23:0] ref_seed = 24'hffffff;

// CRC24 over a whole segment, one bit per step, msb of each word first
// the caller passes the words already prepared, control CRC field zeroed
function automatic logic [23:0] ref_crc24(input logic [63:0] words[$]);
	logic [23:0] c;
	logic        fb;
	c = ref_seed;
	foreach (words[i]) begin
		for (int b = 63; b >= 0; b--) begin
			fb = c[23] ^ words[i][b];
			c = {c[22:0], 1'b0};
			if (fb) begin
				c = c ^ ref_poly;
			end
		end
	end
	return c;
endfunction

// 32 bit xorshift with the 13, 17, 5 shift triple
// state must never be zero, the seed takes care of that
function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

`endif

// ==== bench/tb_crc24_checker.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the CRC24 checker, builds a stimulus table and plays it
// results are matched in order against a queue filled by the model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_crc24_checker;

	localparam int err_cnt_w = 16;

	// one expected segment result
	typedef struct packed {
		crc24_pkg::crc24_t crc;
		logic              err;
	} exp_t;

	logic                      clk;
	logic                      arst;
	logic                      ena;
	logic                      valid;
	ilkn_word_pkg::ilkn_beat_t beat;
	logic                      done;
	logic                      crc_err;
	crc24_pkg::crc24_t         crc_value;
	logic [err_cnt_w-1:0]      err_count;

	// stimulus table, one entry per clock slot
	logic                      slot_ena[$];
	logic                      slot_valid[$];
	ilkn_word_pkg::ilkn_beat_t slot_beat[$];

	exp_t        exp_q[$];
	exp_t        cur_exp;
	logic [63:0] seg_words[$];
	logic [31:0] rng_state;
	int          n_corrupt = 0;
	int          n_segments = 0;
	int          n_checked = 0;
	int          mismatch_errs = 0;
	int          other_errs = 0;
	int          cycles = 0;
	int          cycle_limit = 0;

	`include "crc24_ref.svh"

	crc24_checker_top #(
		.err_cnt_w (err_cnt_w)
	) crc24_checker_top_i (
		.clk       (clk),
		.arst      (arst),
		.ena       (ena),
		.valid     (valid),
		.beat      (beat),
		.done      (done),
		.crc_err   (crc_err),
		.crc_value (crc_value),
		.err_count (err_count)
	);

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	task automatic add_slot(input logic e, input logic v, input ilkn_word_pkg::ilkn_beat_t b);
		slot_ena.push_back(e);
		slot_valid.push_back(v);
		slot_beat.push_back(b);
	endtask

	// optional idle slots ahead of the beat, either a stall or a bubble
	task automatic add_beat(input ilkn_word_pkg::ilkn_beat_t b, input logic gaps);
		int                        n_idle;
		ilkn_word_pkg::ilkn_beat_t junk;
		n_idle = gaps ? int'(next_rand() % 32'd4) : 0;
		for (int i = 0; i < n_idle; i++) begin
			junk.is_ctrl = 1'b1;
			junk.word.raw = {next_rand(), next_rand()};
			// a stall presents a live looking control word that must be ignored
			if (next_rand() % 32'd2 == 32'd0) begin
				add_slot(1'b0, 1'b1, junk);
			end else begin
				add_slot(1'b1, 1'b0, junk);
			end
		end
		add_slot(1'b1, 1'b1, b);
	endtask

	// data words, then the closing control word carrying the CRC field
	task automatic add_segment(input int n_words, input logic corrupt, input logic gaps);
		ilkn_word_pkg::ilkn_word_u cw;
		ilkn_word_pkg::ilkn_beat_t b;
		crc24_pkg::crc24_t         crc;
		exp_t                      e;
		seg_words.delete();
		for (int i = 0; i < n_words; i++) begin
			b.is_ctrl = 1'b0;
			b.word.raw = {next_rand(), next_rand()};
			seg_words.push_back(b.word.raw);
			add_beat(b, gaps);
		end
		cw.raw = {next_rand(), next_rand()};
		cw.ctrl.crc24 = '0;
		seg_words.push_back(cw.raw);
		crc = ref_crc24(seg_words);
		// a corrupted field differs from the true CRC in one bit
		cw.ctrl.crc24 = corrupt ? crc ^ (24'h000001 << (next_rand() % 32'd24)) : crc;
		e.crc = crc;
		e.err = corrupt;
		exp_q.push_back(e);
		if (corrupt) begin
			n_corrupt++;
		end
		b.is_ctrl = 1'b1;
		b.word = cw;
		add_beat(b, gaps);
	endtask

	task automatic build_stimulus();
		ilkn_word_pkg::ilkn_beat_t open_b;
		rng_state = 32'hdaac6348;
		// opening control word, its random CRC field is never compared
		open_b.is_ctrl = 1'b1;
		open_b.word.raw = {next_rand(), next_rand()};
		add_beat(open_b, 1'b0);
		add_segment(3, 1'b0, 1'b0);
		add_segment(2, 1'b1, 1'b0);
		add_segment(0, 1'b0, 1'b0);
		// back to back random segments, then the same with gaps and stalls
		for (int s = 0; s < 24; s++) begin
			add_segment(int'(next_rand() % 32'd13), next_rand() % 32'd4 == 32'd0, 1'b0);
		end
		for (int s = 0; s < 24; s++) begin
			add_segment(int'(next_rand() % 32'd13), next_rand() % 32'd4 == 32'd0, 1'b1);
		end
		n_segments = exp_q.size();
		cycle_limit = 8 + slot_ena.size() + 50;
	endtask

	task automatic report_counts();
		$display("checked %0d of %0d segments, %0d mismatch errors, %0d other errors",
			n_checked, n_segments, mismatch_errs, other_errs);
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////
	// stimulus and end of run
	////////////////////////////////////////////////////////////////////////

	initial begin
		arst = 1'b1;
		ena = 1'b0;
		valid = 1'b0;
		beat = '0;
		build_stimulus();
		repeat (8) @(negedge clk);
		arst <= 1'b0;
		foreach (slot_ena[i]) begin
			@(negedge clk);
			ena <= slot_ena[i];
			valid <= slot_valid[i];
			beat <= slot_beat[i];
		end
		@(negedge clk);
		ena <= 1'b1;
		valid <= 1'b0;
		beat <= '0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		// a few more cycles to catch a stray done pulse
		repeat (10) @(negedge clk);
		assert (int'(err_count) == n_corrupt) else begin
			mismatch_errs++;
			$display("mismatch at %0t: err_count got %0d expected %0d",
				$time, err_count, n_corrupt);
		end
		report_counts();
		if (mismatch_errs + other_errs == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// outputs move on the rising edge, so they are read on the falling one
	always @(negedge clk) begin
		if (!arst && done) begin
			assert (exp_q.size() != 0) else begin
				other_errs++;
				$display("done pulse at %0t with no segment outstanding", $time);
			end
			if (exp_q.size() != 0) begin
				cur_exp = exp_q.pop_front();
				n_checked++;
				assert (crc_value == cur_exp.crc) else begin
					mismatch_errs++;
					$display("mismatch at %0t: crc_value got %h expected %h",
						$time, crc_value, cur_exp.crc);
				end
				assert (crc_err == cur_exp.err) else begin
					mismatch_errs++;
					$display("mismatch at %0t: crc_err got %b expected %b",
						$time, crc_err, cur_exp.err);
				end
			end
		end
		assert (!crc_err || done) else begin
			other_errs++;
			$display("crc_err high without done at %0t", $time);
		end
	end

	// watchdog, the limit is set once the stimulus table is built
	initial begin
		while (cycle_limit == 0 || cycles <= cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles with %0d results outstanding", cycles, exp_q.size());
		report_counts();
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+bench
rtl/crc24_pkg.sv
rtl/ilkn_word_pkg.sv
rtl/word_decode.sv
rtl/crc24_accum.sv
rtl/crc_result_check.sv
rtl/crc24_checker_top.sv
bench/tb_crc24_checker.sv

// ==== run.sh ====
#!/bin/sh
# builds the CRC24 checker testbench with Verilator and runs it once
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f \
	--top-module tb_crc24_checker -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -qx "TB PASSED" && exit 0 || exit 1
